// File: logic/udp_rx_pkg.sv
package udp_rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [1:0]  chan_t;
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len_t;
    typedef logic [16:0] fifo_entry_t;  // {last, word}

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_eth_head,
        st_ip_head,
        st_udp_head,
        st_rx_data,
        st_rx_end
    } parse_state_t;

    localparam int NUM_CHAN   = 4;
    localparam int FIFO_DEPTH = 16;

    // ******************************
    // addressing of this board
    localparam mac_t  BOARD_MAC      = 48'h02_1a_3c_4d_5e_6f;
    localparam mac_t  BROADCAST_MAC  = 48'hff_ff_ff_ff_ff_ff;
    localparam ip_t   BOARD_IP       = 32'hc0_a8_01_0b;  // 192.168.1.11
    localparam word_t ETH_TYPE_IPV4  = 16'h0800;
    localparam byte_t UDP_PROTO      = 8'd17;
    localparam port_t UDP_BASE_PORT  = 16'd5000;  // ports 5000..5003 accepted
    localparam len_t  UDP_HEAD_BYTES = 16'd8;

endpackage

// File: logic/gmii_udp_parser.sv
`timescale 1ns/1ps

module gmii_udp_parser (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      gmii_rx_dv,
    input  udp_rx_pkg::byte_t         gmii_rxd,
    output logic                      word_en,
    output logic                      word_last,
    output logic                      pkt_done,
    output udp_rx_pkg::word_t         word_data,
    output udp_rx_pkg::chan_t         word_chan,
    output udp_rx_pkg::chan_t         pkt_chan,
    output udp_rx_pkg::len_t          pkt_bytes
);

    udp_rx_pkg::parse_state_t state;

    logic [5:0]         hdr_cnt;    // byte index inside current header
    logic [3:0]         ihl;        // ip header length in 32-bit words
    logic [5:0]         ip_last;
    udp_rx_pkg::len_t   data_cnt;
    udp_rx_pkg::len_t   data_len;
    udp_rx_pkg::len_t   udp_len;
    udp_rx_pkg::byte_t  prev_byte;
    udp_rx_pkg::mac_t   dst_mac;
    logic [23:0]        dst_ip_hi;  // first three bytes of dest ip
    logic [15:0]        pair16;
    udp_rx_pkg::port_t  port_off;

    // 16-bit header fields end on the current byte
    assign pair16   = {prev_byte, gmii_rxd};
    assign port_off = pair16 - udp_rx_pkg::UDP_BASE_PORT;
    assign ip_last  = {ihl, 2'b00} - 6'd1;

    // ******************************
    // state machine and strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= udp_rx_pkg::st_idle;
            hdr_cnt   <= '0;
            ihl       <= '0;
            data_cnt  <= '0;
            word_en   <= 1'b0;
            word_last <= 1'b0;
            word_chan <= '0;
            pkt_done  <= 1'b0;
            pkt_chan  <= '0;
            pkt_bytes <= '0;
        end else begin
            word_en   <= 1'b0;
            word_last <= 1'b0;
            pkt_done  <= 1'b0;
            case (state)
                udp_rx_pkg::st_idle: begin
                    if (gmii_rx_dv) begin
                        if (gmii_rxd == 8'h55) begin
                            state   <= udp_rx_pkg::st_preamble;
                            hdr_cnt <= 6'd1;  // first 0x55 already seen
                        end else begin
                            state <= udp_rx_pkg::st_rx_end;
                        end
                    end
                end
                udp_rx_pkg::st_preamble: begin
                    if (!gmii_rx_dv) begin
                        state <= udp_rx_pkg::st_rx_end;
                    end else if (gmii_rxd == 8'h55 && hdr_cnt < 6'd7) begin
                        hdr_cnt <= hdr_cnt + 6'd1;
                    end else if (gmii_rxd == 8'hd5 && hdr_cnt == 6'd7) begin
                        state   <= udp_rx_pkg::st_eth_head;
                        hdr_cnt <= '0;
                    end else begin
                        state <= udp_rx_pkg::st_rx_end;
                    end
                end
                udp_rx_pkg::st_eth_head: begin
                    hdr_cnt <= hdr_cnt + 6'd1;
                    if (!gmii_rx_dv) begin
                        state <= udp_rx_pkg::st_rx_end;
                    end else if (hdr_cnt == 6'd13) begin
                        hdr_cnt <= '0;
                        if ((dst_mac == udp_rx_pkg::BOARD_MAC ||
                             dst_mac == udp_rx_pkg::BROADCAST_MAC) &&
                            pair16 == udp_rx_pkg::ETH_TYPE_IPV4)
                            state <= udp_rx_pkg::st_ip_head;
                        else
                            state <= udp_rx_pkg::st_rx_end;
                    end
                end
                udp_rx_pkg::st_ip_head: begin
                    hdr_cnt <= hdr_cnt + 6'd1;
                    if (hdr_cnt == 6'd0)
                        ihl <= gmii_rxd[3:0];
                    if (!gmii_rx_dv) begin
                        state <= udp_rx_pkg::st_rx_end;
                    end else if (hdr_cnt == 6'd0 &&
                                 (gmii_rxd[7:4] != 4'd4 || gmii_rxd[3:0] < 4'd5)) begin
                        state <= udp_rx_pkg::st_rx_end;  // not ipv4 or bad ihl
                    end else if (hdr_cnt == 6'd9 && gmii_rxd != udp_rx_pkg::UDP_PROTO) begin
                        state <= udp_rx_pkg::st_rx_end;
                    end else if (hdr_cnt == 6'd19 &&
                                 {dst_ip_hi, gmii_rxd} != udp_rx_pkg::BOARD_IP) begin
                        state <= udp_rx_pkg::st_rx_end;
                    end else if (hdr_cnt == ip_last) begin
                        // option bytes, if any, are skipped up to here
                        state   <= udp_rx_pkg::st_udp_head;
                        hdr_cnt <= '0;
                    end
                end
                udp_rx_pkg::st_udp_head: begin
                    hdr_cnt <= hdr_cnt + 6'd1;
                    if (!gmii_rx_dv) begin
                        state <= udp_rx_pkg::st_rx_end;
                    end else if (hdr_cnt == 6'd3) begin
                        if (port_off >= udp_rx_pkg::NUM_CHAN)
                            state <= udp_rx_pkg::st_rx_end;  // outside port window
                        else
                            word_chan <= udp_rx_pkg::chan_t'(port_off);
                    end else if (hdr_cnt == 6'd7) begin
                        hdr_cnt  <= '0;
                        data_cnt <= '0;
                        if (udp_len > udp_rx_pkg::UDP_HEAD_BYTES)
                            state <= udp_rx_pkg::st_rx_data;
                        else
                            state <= udp_rx_pkg::st_rx_end;  // empty payload
                    end
                end
                udp_rx_pkg::st_rx_data: begin
                    if (!gmii_rx_dv) begin
                        state <= udp_rx_pkg::st_rx_end;
                    end else begin
                        data_cnt <= data_cnt + 16'd1;
                        if (data_cnt == data_len - 16'd1) begin
                            word_en   <= 1'b1;
                            word_last <= 1'b1;
                            pkt_done  <= 1'b1;
                            pkt_bytes <= data_len;
                            pkt_chan  <= word_chan;
                            state     <= udp_rx_pkg::st_rx_end;
                        end else if (data_cnt[0]) begin
                            word_en <= 1'b1;  // second byte of a pair
                        end
                    end
                end
                udp_rx_pkg::st_rx_end: begin
                    // fcs and anything else until dv drops
                    if (!gmii_rx_dv)
                        state <= udp_rx_pkg::st_idle;
                end
                default: state <= udp_rx_pkg::st_idle;
            endcase
        end
    end

    // ******************************
    // header fields and payload word
    always_ff @(posedge clk) begin
        prev_byte <= gmii_rxd;
        if (state == udp_rx_pkg::st_eth_head && hdr_cnt < 6'd6)
            dst_mac <= {dst_mac[39:0], gmii_rxd};
        if (state == udp_rx_pkg::st_ip_head && hdr_cnt >= 6'd16 && hdr_cnt <= 6'd18)
            dst_ip_hi <= {dst_ip_hi[15:0], gmii_rxd};
        if (state == udp_rx_pkg::st_udp_head && hdr_cnt == 6'd5)
            udp_len <= pair16;
        if (state == udp_rx_pkg::st_udp_head && hdr_cnt == 6'd7)
            data_len <= udp_len - udp_rx_pkg::UDP_HEAD_BYTES;
        if (state == udp_rx_pkg::st_rx_data) begin
            if (data_cnt[0])
                word_data <= pair16;              // big-endian pair
            else
                word_data <= {gmii_rxd, 8'h00};   // odd tail, zero low byte
        end
    end

endmodule

// File: logic/port_word_fifo.sv
`timescale 1ns/1ps

module port_word_fifo #(
    parameter udp_rx_pkg::chan_t CHAN_ID = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    word_en,
    input  logic                    word_last,
    input  udp_rx_pkg::word_t       word_data,
    input  udp_rx_pkg::chan_t       word_chan,
    input  logic                    pop,
    output logic                    empty,
    output udp_rx_pkg::fifo_entry_t head
);

    udp_rx_pkg::fifo_entry_t mem [udp_rx_pkg::FIFO_DEPTH];

    logic [$clog2(udp_rx_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(udp_rx_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(udp_rx_pkg::FIFO_DEPTH):0]   count;

    logic full;
    logic wr_hit;   // word tagged for this channel
    logic wr_ok;
    logic rd_ok;

    assign wr_hit = word_en && (word_chan == CHAN_ID);
    assign wr_ok  = wr_hit && !full;    // dropped when full
    assign rd_ok  = pop && !empty;
    assign empty  = (count == '0);
    assign full   = (count == udp_rx_pkg::FIFO_DEPTH);
    assign head   = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (rd_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wr_ok)
            mem[wr_ptr] <= {word_last, word_data};
    end

endmodule

// File: logic/rr_drain.sv
`timescale 1ns/1ps

module rr_drain (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [udp_rx_pkg::NUM_CHAN-1:0]   empty,
    input  udp_rx_pkg::fifo_entry_t           heads [udp_rx_pkg::NUM_CHAN],
    output logic [udp_rx_pkg::NUM_CHAN-1:0]   pop,
    output logic                              out_valid,
    output logic                              out_last,
    output udp_rx_pkg::word_t                 out_data,
    output udp_rx_pkg::chan_t                 out_chan
);

    udp_rx_pkg::chan_t last_chan;   // channel served most recently
    udp_rx_pkg::chan_t pick;
    logic              found;

    // ******************************
    // rotating priority search
    always_comb begin
        udp_rx_pkg::chan_t cand;
        found = 1'b0;
        pick  = last_chan;
        cand  = last_chan;
        for (int k = 1; k <= udp_rx_pkg::NUM_CHAN; k++) begin
            cand = udp_rx_pkg::chan_t'(last_chan + k);  // wraps mod 4
            if (!found && !empty[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    // one-hot pop, at most one per cycle
    always_comb begin
        pop = '0;
        if (found)
            pop[pick] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_chan <= udp_rx_pkg::chan_t'(udp_rx_pkg::NUM_CHAN - 1);  // chan 0 first
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= found;
            out_last  <= found && heads[pick][16];  // bit 16 is the last flag
            if (found)
                last_chan <= pick;
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            out_data <= heads[pick][15:0];
            out_chan <= pick;
        end
    end

endmodule

// File: logic/udp_port_rx_top.sv
`timescale 1ns/1ps

module udp_port_rx_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                gmii_rx_dv,
    input  udp_rx_pkg::byte_t   gmii_rxd,
    output logic                pkt_done,
    output udp_rx_pkg::len_t    pkt_bytes,
    output udp_rx_pkg::chan_t   pkt_chan,
    output logic                out_valid,
    output udp_rx_pkg::word_t   out_data,
    output logic                out_last,
    output udp_rx_pkg::chan_t   out_chan
);

    logic                               word_en;
    logic                               word_last;
    udp_rx_pkg::word_t                  word_data;
    udp_rx_pkg::chan_t                  word_chan;
    logic [udp_rx_pkg::NUM_CHAN-1:0]    fifo_empty;
    logic [udp_rx_pkg::NUM_CHAN-1:0]    fifo_pop;
    udp_rx_pkg::fifo_entry_t            fifo_head [udp_rx_pkg::NUM_CHAN];

    gmii_udp_parser u_parser (
        .clk        (clk),
        .rst_n      (rst_n),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rxd   (gmii_rxd),
        .word_en    (word_en),
        .word_last  (word_last),
        .pkt_done   (pkt_done),
        .word_data  (word_data),
        .word_chan  (word_chan),
        .pkt_chan   (pkt_chan),
        .pkt_bytes  (pkt_bytes)
    );

    // ******************************
    // one buffer per udp port
    for (genvar i = 0; i < udp_rx_pkg::NUM_CHAN; i++) begin : g_chan
        port_word_fifo #(
            .CHAN_ID (udp_rx_pkg::chan_t'(i))
        ) u_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .word_en   (word_en),
            .word_last (word_last),
            .word_data (word_data),
            .word_chan (word_chan),
            .pop       (fifo_pop[i]),
            .empty     (fifo_empty[i]),
            .head      (fifo_head[i])
        );
    end

    rr_drain u_drain (
        .clk       (clk),
        .rst_n     (rst_n),
        .empty     (fifo_empty),
        .heads     (fifo_head),
        .pop       (fifo_pop),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_data  (out_data),
        .out_chan  (out_chan)
    );

endmodule

// File: verif/udp_port_rx_properties.sv
`timescale 1ns/1ps

module udp_port_rx_properties (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              word_en,
    input udp_rx_pkg::chan_t                 word_chan,
    input logic [udp_rx_pkg::NUM_CHAN-1:0]   fifo_empty,
    input logic [udp_rx_pkg::NUM_CHAN-1:0]   fifo_pop,
    input logic                              out_valid,
    input logic                              out_last
);

    int fail_count = 0;
    int fill [udp_rx_pkg::NUM_CHAN];  // occupancy of each fifo

    // ******************************
    // occupancy model, drops a write when full like the fifo
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < udp_rx_pkg::NUM_CHAN; i++)
                fill[i] <= 0;
        end else begin
            for (int i = 0; i < udp_rx_pkg::NUM_CHAN; i++)
                fill[i] <= fill[i]
                    + ((word_en && word_chan == udp_rx_pkg::chan_t'(i) &&
                        fill[i] < udp_rx_pkg::FIFO_DEPTH) ? 1 : 0)
                    - ((fifo_pop[i] && !fifo_empty[i]) ? 1 : 0);
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin $error("out_valid high during reset"); fail_count++; end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        word_en |-> fill[word_chan] < udp_rx_pkg::FIFO_DEPTH)
        else begin $error("word written into a full fifo"); fail_count++; end

    a_one_pop: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(fifo_pop))
        else begin $error("more than one pop bit set"); fail_count++; end

    a_last_valid: assert property (@(posedge clk) disable iff (!rst_n) out_last |-> out_valid)
        else begin $error("out_last without out_valid"); fail_count++; end

endmodule

bind udp_port_rx_top udp_port_rx_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .word_en    (word_en),
    .word_chan  (word_chan),
    .fifo_empty (fifo_empty),
    .fifo_pop   (fifo_pop),
    .out_valid  (out_valid),
    .out_last   (out_last)
);

// File: verif/udp_port_rx_tb.sv
`timescale 1ns/1ps

module udp_port_rx_tb;

    localparam int FRAME_COUNT      = 21;
    localparam int MAX_FRAME_CYCLES = 8 + 14 + 24 + 8 + 40 + 4 + 12;  // longest frame plus gap
    localparam int WATCHDOG_CYCLES  = 5 + FRAME_COUNT * MAX_FRAME_CYCLES + 2000;
    localparam udp_rx_pkg::mac_t SRC_MAC = 48'h02_00_00_00_00_01;
    localparam udp_rx_pkg::ip_t  SRC_IP  = 32'hc0_a8_01_02;

    logic clk = 1'b0;
    logic rst_n;
    logic gmii_rx_dv;
    udp_rx_pkg::byte_t gmii_rxd;
    logic pkt_done;
    udp_rx_pkg::len_t pkt_bytes;
    udp_rx_pkg::chan_t pkt_chan;
    logic out_valid;
    udp_rx_pkg::word_t out_data;
    logic out_last;
    udp_rx_pkg::chan_t out_chan;

    udp_rx_pkg::fifo_entry_t exp_q [udp_rx_pkg::NUM_CHAN][$];  // {last, word} per channel
    logic [17:0] exp_pkt [$];                                  // {chan, bytes}
    logic [31:0] rng_state = 32'd73;
    string test_name = "reset";
    int word_errors = 0;
    int pkt_errors = 0;
    int other_errors = 0;
    int prop_fails = 0;

    udp_port_rx_top u_udp_port_rx_top (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int pending_words();
        int n = 0;
        for (int c = 0; c < udp_rx_pkg::NUM_CHAN; c++)
            n += exp_q[c].size();
        return n + exp_pkt.size();
    endfunction

    task automatic put_byte(input udp_rx_pkg::byte_t b);
        gmii_rx_dv = 1'b1;
        gmii_rxd   = b;
        @(posedge clk);
        #1;
    endtask

    // ******************************
    // frame builder with expected words pushed up front
    task automatic send_frame(input udp_rx_pkg::mac_t mac, input logic [15:0] etype,
            input udp_rx_pkg::ip_t ip, input logic [7:0] proto,
            input udp_rx_pkg::port_t port, input int ihl, input int plen, input bit good);
        udp_rx_pkg::byte_t fb [$];
        udp_rx_pkg::byte_t pay [$];
        logic [111:0] eth_hdr;
        logic [159:0] ip_hdr;
        logic [63:0] udp_hdr;
        udp_rx_pkg::chan_t ch;
        logic lst;
        eth_hdr = {mac, SRC_MAC, etype};
        ip_hdr  = {4'h4, 4'(ihl), 8'h00, 16'(ihl * 4 + 8 + plen), 16'h1c46, 16'h4000,
                   8'h40, proto, 16'h0000, SRC_IP, ip};
        udp_hdr = {16'd40000, port, 16'(8 + plen), 16'h0000};
        ch = udp_rx_pkg::chan_t'(port - udp_rx_pkg::UDP_BASE_PORT);
        repeat (7) fb.push_back(8'h55);
        fb.push_back(8'hd5);
        for (int i = 13; i >= 0; i--) fb.push_back(eth_hdr[i*8 +: 8]);
        for (int i = 19; i >= 0; i--) fb.push_back(ip_hdr[i*8 +: 8]);
        repeat ((ihl - 5) * 4) fb.push_back(8'h01);  // nop options
        for (int i = 7; i >= 0; i--) fb.push_back(udp_hdr[i*8 +: 8]);
        repeat (plen) pay.push_back(udp_rx_pkg::byte_t'(next_rand()));
        foreach (pay[i]) fb.push_back(pay[i]);
        repeat (4) fb.push_back(8'hee);  // dummy fcs bytes
        if (good) begin
            for (int k = 0; k < plen; k += 2) begin
                lst = (k + 2 >= plen);
                exp_q[ch].push_back({lst, pay[k], (k + 1 < plen) ? pay[k+1] : 8'h00});
            end
            exp_pkt.push_back({ch, 16'(plen)});
        end
        foreach (fb[i]) put_byte(fb[i]);
        gmii_rx_dv = 1'b0;
        gmii_rxd   = 8'h00;
        repeat (12) @(posedge clk);
        #1;
    endtask

    task automatic reject_then_good(input string name, input udp_rx_pkg::mac_t mac,
            input logic [15:0] etype, input udp_rx_pkg::ip_t ip, input logic [7:0] proto,
            input udp_rx_pkg::port_t port);
        test_name = name;
        send_frame(mac, etype, ip, proto, port, 5, 12, 1'b0);
        test_name = {name, "_recovery"};
        send_frame(udp_rx_pkg::BOARD_MAC, udp_rx_pkg::ETH_TYPE_IPV4, udp_rx_pkg::BOARD_IP,
                   udp_rx_pkg::UDP_PROTO, udp_rx_pkg::UDP_BASE_PORT + 16'd1, 5, 12, 1'b1);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        udp_rx_pkg::fifo_entry_t want;
        logic [17:0] want_pkt;
        if (rst_n && out_valid) begin
            assert (exp_q[out_chan].size() != 0)
            else begin
                word_errors++;
                $display("ERROR: %s: word %h on channel %0d that nobody expected",
                         test_name, out_data, out_chan);
            end
            if (exp_q[out_chan].size() != 0) begin
                want = exp_q[out_chan].pop_front();
                assert ({out_last, out_data} == want)
                else begin
                    word_errors++;
                    $display("CHECK FAILED %s: expected %h actual %h",
                             test_name, want, {out_last, out_data});
                end
            end
        end
        if (rst_n && pkt_done) begin
            assert (exp_pkt.size() != 0)
            else begin
                pkt_errors++;
                $display("ERROR: %s: pkt_done for a frame that should be dropped", test_name);
            end
            if (exp_pkt.size() != 0) begin
                want_pkt = exp_pkt.pop_front();
                assert ({pkt_chan, pkt_bytes} == want_pkt)
                else begin
                    pkt_errors++;
                    $display("CHECK FAILED %s: expected chan/bytes %h actual %h",
                             test_name, want_pkt, {pkt_chan, pkt_bytes});
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        gmii_rx_dv = 1'b0;
        gmii_rxd   = 8'h00;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        test_name = "even_port";
        for (int c = 0; c < udp_rx_pkg::NUM_CHAN; c++)
            send_frame(udp_rx_pkg::BOARD_MAC, udp_rx_pkg::ETH_TYPE_IPV4, udp_rx_pkg::BOARD_IP,
                       udp_rx_pkg::UDP_PROTO, udp_rx_pkg::UDP_BASE_PORT + 16'(c), 5,
                       10 + 2 * c, 1'b1);
        test_name = "odd_length";
        send_frame(udp_rx_pkg::BOARD_MAC, udp_rx_pkg::ETH_TYPE_IPV4, udp_rx_pkg::BOARD_IP,
                   udp_rx_pkg::UDP_PROTO, udp_rx_pkg::UDP_BASE_PORT + 16'd2, 5, 7, 1'b1);

        reject_then_good("wrong_mac", 48'h02_1a_3c_4d_5e_70, udp_rx_pkg::ETH_TYPE_IPV4,
                         udp_rx_pkg::BOARD_IP, udp_rx_pkg::UDP_PROTO, udp_rx_pkg::UDP_BASE_PORT);
        reject_then_good("wrong_ethertype", udp_rx_pkg::BOARD_MAC, 16'h86dd,
                         udp_rx_pkg::BOARD_IP, udp_rx_pkg::UDP_PROTO, udp_rx_pkg::UDP_BASE_PORT);
        reject_then_good("wrong_ip", udp_rx_pkg::BOARD_MAC, udp_rx_pkg::ETH_TYPE_IPV4,
                         32'hc0_a8_01_0c, udp_rx_pkg::UDP_PROTO, udp_rx_pkg::UDP_BASE_PORT);
        reject_then_good("not_udp", udp_rx_pkg::BOARD_MAC, udp_rx_pkg::ETH_TYPE_IPV4,
                         udp_rx_pkg::BOARD_IP, 8'd6, udp_rx_pkg::UDP_BASE_PORT);
        reject_then_good("port_outside", udp_rx_pkg::BOARD_MAC, udp_rx_pkg::ETH_TYPE_IPV4,
                         udp_rx_pkg::BOARD_IP, udp_rx_pkg::UDP_PROTO,
                         udp_rx_pkg::UDP_BASE_PORT + 16'd4);

        test_name = "broadcast";
        send_frame(udp_rx_pkg::BROADCAST_MAC, udp_rx_pkg::ETH_TYPE_IPV4, udp_rx_pkg::BOARD_IP,
                   udp_rx_pkg::UDP_PROTO, udp_rx_pkg::UDP_BASE_PORT, 5, 20, 1'b1);
        test_name = "ip_options";
        send_frame(udp_rx_pkg::BOARD_MAC, udp_rx_pkg::ETH_TYPE_IPV4, udp_rx_pkg::BOARD_IP,
                   udp_rx_pkg::UDP_PROTO, udp_rx_pkg::UDP_BASE_PORT + 16'd3, 6, 15, 1'b1);

        // minimum gap between frames on alternating channels
        test_name = "back_to_back";
        send_frame(udp_rx_pkg::BOARD_MAC, udp_rx_pkg::ETH_TYPE_IPV4, udp_rx_pkg::BOARD_IP,
                   udp_rx_pkg::UDP_PROTO, udp_rx_pkg::UDP_BASE_PORT + 16'd3, 5, 40, 1'b1);
        send_frame(udp_rx_pkg::BOARD_MAC, udp_rx_pkg::ETH_TYPE_IPV4, udp_rx_pkg::BOARD_IP,
                   udp_rx_pkg::UDP_PROTO, udp_rx_pkg::UDP_BASE_PORT + 16'd1, 5, 22, 1'b1);
        send_frame(udp_rx_pkg::BOARD_MAC, udp_rx_pkg::ETH_TYPE_IPV4, udp_rx_pkg::BOARD_IP,
                   udp_rx_pkg::UDP_PROTO, udp_rx_pkg::UDP_BASE_PORT, 5, 31, 1'b1);
        send_frame(udp_rx_pkg::BOARD_MAC, udp_rx_pkg::ETH_TYPE_IPV4, udp_rx_pkg::BOARD_IP,
                   udp_rx_pkg::UDP_PROTO, udp_rx_pkg::UDP_BASE_PORT + 16'd2, 5, 18, 1'b1);

        for (int i = 0; i < 100 && pending_words() != 0; i++)
            @(posedge clk);
        repeat (4) @(posedge clk);  // room for a stray word
        if (pending_words() != 0) begin
            other_errors++;
            $display("ERROR: %0d expected words or packet records never came out",
                     pending_words());
        end
        prop_fails = u_udp_port_rx_top.u_props.fail_count;
        $display("summary: %0d word, %0d packet, %0d other errors, %0d assertion failures",
                 word_errors, pkt_errors, other_errors, prop_fails);
        if (word_errors + pkt_errors + other_errors + prop_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: project.f
logic/udp_rx_pkg.sv
logic/gmii_udp_parser.sv
logic/port_word_fifo.sv
logic/rr_drain.sv
logic/udp_port_rx_top.sv
verif/udp_port_rx_properties.sv
verif/udp_port_rx_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module udp_port_rx_tb -Mdir obj_dir -o udp_port_rx_sim
	./obj_dir/udp_port_rx_sim | tee $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG) || (echo "test failed, see $(LOG)"; exit 1)
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)
